//--- include/sbox_consts.svh
`ifndef SBOX_CONSTS_SVH
`define SBOX_CONSTS_SVH

// six 6-bit lanes make up the 36-bit cipher state.
`define SBOX_LANES 6

// bits per GF(2^6) element.
`define SBOX_WIDTH 6

// request strobe to result strobe, in clock cycles.
`define SBOX_LATENCY 2

`endif

//--- logic/gf_sbox_pkg.sv
`include "sbox_consts.svh"

package gf_sbox_pkg;

  // GF(4) in basis {1, w} with w^2 = w + 1, bit 1 holds the w coefficient.
  typedef logic [1:0] gf4_t;

  typedef logic [`SBOX_WIDTH-1:0] gf6_t; // polynomial basis.

  // GF((2^2)^3) element c2*b^2 + c1*b + c0, where b^3 = b^2 + w^2*b + w.
  typedef struct packed {
    gf4_t c2;
    gf4_t c1;
    gf4_t c0;
  } tower_t;

  typedef enum logic {
    SBOX_FWD = 1'b0, // x^19.
    SBOX_INV = 1'b1  // x^10.
  } sbox_op_e;

  typedef gf6_t [`SBOX_LANES-1:0] sbox_state_t;

  typedef struct packed {
    sbox_op_e    op;
    sbox_state_t state;
  } sbox_req_t;

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_square(gf4_t a);
    return {a[1], a[0] ^ a[1]};
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic t;
    t = a[1] & b[1];
    return {(a[0] & b[1]) ^ (a[1] & b[0]) ^ t, (a[0] & b[0]) ^ t};
  endfunction

  // multiply by one of the four field constants 0, 1, w, w^2.
  function automatic gf4_t gf4_cmul(gf4_t a, gf4_t k);
    gf4_t r;
    case (k)
      2'd0:    r = 2'b00;
      2'd1:    r = a;
      2'd2:    r = {a[0] ^ a[1], a[1]};
      default: r = {a[0], a[0] ^ a[1]};
    endcase
    return r;
  endfunction

  // a^3 * b, where a^3 is 1 for any nonzero a.
  function automatic gf4_t gf4_cube_sel(gf4_t a, gf4_t b);
    logic nz;
    nz = a[0] | a[1];
    return {nz & b[1], nz & b[0]};
  endfunction

  // polynomial basis into tower basis.
  function automatic tower_t to_tower(gf6_t a);
    logic [5:0] b;
    b[0] = a[0] ^ a[1];
    b[1] = a[1] ^ a[5];
    b[2] = a[1] ^ a[3] ^ a[4] ^ a[5];
    b[3] = a[2] ^ a[3] ^ a[4] ^ a[5];
    b[4] = a[1] ^ a[3];
    b[5] = a[1] ^ a[2] ^ a[4];
    return tower_t'(b);
  endfunction

  // tower basis back into polynomial basis.
  function automatic gf6_t from_tower(tower_t t);
    logic [5:0] a;
    logic [5:0] b;
    a = t;
    b[0] = a[0] ^ a[1] ^ a[3] ^ a[4] ^ a[5];
    b[1] = a[1] ^ a[3] ^ a[4] ^ a[5];
    b[2] = a[1] ^ a[2] ^ a[4] ^ a[5];
    b[3] = a[1] ^ a[3] ^ a[5];
    b[4] = a[2] ^ a[3] ^ a[5];
    b[5] = a[3] ^ a[4] ^ a[5];
    return b;
  endfunction

endpackage

//--- logic/tower_power19.sv
`timescale 1ns/100ps

module tower_power19
  import gf_sbox_pkg::*;
(
  input  tower_t a,
  output tower_t b
);

  localparam int n_terms = 15;

  // per-term weights for each output coefficient, term 0 first.
  localparam gf4_t k_c0 [n_terms] = '{
    2'd1, 2'd0, 2'd1, 2'd3, 2'd3, 2'd1, 2'd0, 2'd3,
    2'd1, 2'd3, 2'd1, 2'd0, 2'd1, 2'd1, 2'd0
  };
  localparam gf4_t k_c1 [n_terms] = '{
    2'd0, 2'd3, 2'd3, 2'd1, 2'd3, 2'd1, 2'd3, 2'd1,
    2'd2, 2'd2, 2'd2, 2'd0, 2'd2, 2'd2, 2'd2
  };
  localparam gf4_t k_c2 [n_terms] = '{
    2'd0, 2'd2, 2'd3, 2'd2, 2'd0, 2'd1, 2'd0, 2'd3,
    2'd3, 2'd3, 2'd0, 2'd3, 2'd2, 2'd0, 2'd2
  };

  gf4_t x0;
  gf4_t x1;
  gf4_t x2;
  gf4_t s0;
  gf4_t s1;
  gf4_t s2;
  gf4_t m01;
  gf4_t m02;
  gf4_t m12;
  gf4_t term [n_terms];

  assign x0 = a.c0;
  assign x1 = a.c1;
  assign x2 = a.c2;

  assign s0 = gf4_square(x0);
  assign s1 = gf4_square(x1);
  assign s2 = gf4_square(x2);

  assign m01 = gf4_mul(x0, x1);
  assign m02 = gf4_mul(x0, x2);
  assign m12 = gf4_mul(x1, x2);

  // linear terms.
  assign term[0] = x0;
  assign term[1] = x1;
  assign term[2] = x2;

  // xi^3 * xj terms.
  assign term[3] = gf4_cube_sel(x0, x1);
  assign term[4] = gf4_cube_sel(x0, x2);
  assign term[5] = gf4_cube_sel(x1, x0);
  assign term[6] = gf4_cube_sel(x1, x2);
  assign term[7] = gf4_cube_sel(x2, x0);
  assign term[8] = gf4_cube_sel(x2, x1);

  // degree four terms.
  assign term[9]  = gf4_mul(s0, s1);
  assign term[10] = gf4_mul(s0, s2);
  assign term[11] = gf4_mul(s1, s2);
  assign term[12] = gf4_mul(s0, m12);
  assign term[13] = gf4_mul(s1, m02);
  assign term[14] = gf4_mul(s2, m01);

  always_comb begin
    b = '0;
    for (int k = 0; k < n_terms; k++) begin
      b.c0 = gf4_add(b.c0, gf4_cmul(term[k], k_c0[k]));
      b.c1 = gf4_add(b.c1, gf4_cmul(term[k], k_c1[k]));
      b.c2 = gf4_add(b.c2, gf4_cmul(term[k], k_c2[k]));
    end
  end

endmodule

//--- logic/tower_power10.sv
`timescale 1ns/100ps

module tower_power10
  import gf_sbox_pkg::*;
(
  input  tower_t a,
  output tower_t b
);

  gf4_t u0;
  gf4_t u1;
  gf4_t u2;
  tower_t sq;  // x^2.
  tower_t e8;  // x^8.
  gf4_t d0;
  gf4_t d1;
  gf4_t d2;
  gf4_t d3;
  gf4_t d4;

  // squaring acts on each coefficient, then b^4 = w*b^2 + b + w folds back.
  assign u0 = gf4_square(a.c0);
  assign u1 = gf4_square(a.c1);
  assign u2 = gf4_square(a.c2);

  assign sq.c2 = gf4_add(gf4_cmul(u2, 2'd2), u1);
  assign sq.c1 = u2;
  assign sq.c0 = gf4_add(gf4_cmul(u2, 2'd2), u0);

  // x^8 = (x^2)^4, the GF(4) Frobenius leaves coefficients alone.
  assign e8.c2 = gf4_cmul(sq.c1, 2'd2);
  assign e8.c1 = gf4_add(gf4_cmul(sq.c2, 2'd3), sq.c1);
  assign e8.c0 = gf4_add(gf4_add(gf4_cmul(sq.c2, 2'd2), gf4_cmul(sq.c1, 2'd2)), sq.c0);

  // schoolbook product x^8 * x^2 up to b^4.
  assign d0 = gf4_mul(e8.c0, sq.c0);
  assign d1 = gf4_add(gf4_mul(e8.c0, sq.c1), gf4_mul(e8.c1, sq.c0));
  assign d2 = gf4_add(gf4_add(gf4_mul(e8.c0, sq.c2), gf4_mul(e8.c1, sq.c1)),
                      gf4_mul(e8.c2, sq.c0));
  assign d3 = gf4_add(gf4_mul(e8.c1, sq.c2), gf4_mul(e8.c2, sq.c1));
  assign d4 = gf4_mul(e8.c2, sq.c2);

  // reduce with b^3 = b^2 + w^2*b + w.
  assign b.c2 = gf4_add(gf4_add(d2, d3), gf4_cmul(d4, 2'd2));
  assign b.c1 = gf4_add(gf4_add(d1, gf4_cmul(d3, 2'd3)), d4);
  assign b.c0 = gf4_add(gf4_add(d0, gf4_cmul(d3, 2'd2)), gf4_cmul(d4, 2'd2));

endmodule

//--- logic/sbox_lane.sv
`timescale 1ns/100ps

module sbox_lane
  import gf_sbox_pkg::*;
(
  input  logic     clk,
  input  logic     stage1_en,
  input  logic     stage2_en,
  input  sbox_op_e op,
  input  gf6_t     din,
  output gf6_t     dout
);

  tower_t mapped;
  tower_t pow19;
  tower_t pow10;
  tower_t powered;
  tower_t stage1_q;

  assign mapped = to_tower(din);

  tower_power19 u_pow19 (
    .a (mapped),
    .b (pow19)
  );

  tower_power10 u_pow10 (
    .a (mapped),
    .b (pow10)
  );

  assign powered = (op == SBOX_INV) ? pow10 : pow19;

  always_ff @(posedge clk) begin
    if (stage1_en) begin
      stage1_q <= powered;
    end
  end

  // back to polynomial basis on the way out.
  always_ff @(posedge clk) begin
    if (stage2_en) begin
      dout <= from_tower(stage1_q);
    end
  end

  // zero is a fixed point of both power maps and of the basis change.
  zero_maps_to_zero: assert property (
    @(posedge clk) (stage1_en && din == '0) |=> (stage1_q == '0)
  );

endmodule

//--- logic/sbox_layer.sv
`timescale 1ns/100ps
`include "sbox_consts.svh"

module sbox_layer
  import gf_sbox_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  input  sbox_req_t   in_req,
  output logic        out_valid,
  output sbox_state_t out_state
);

  logic stage1_valid;

  // valid travels alongside the lane data, no stalls.
  always_ff @(posedge clk) begin
    if (reset) begin
      stage1_valid <= 1'b0;
      out_valid    <= 1'b0;
    end else begin
      stage1_valid <= in_valid;
      out_valid    <= stage1_valid;
    end
  end

  for (genvar i = 0; i < `SBOX_LANES; i++) begin : g_lane
    sbox_lane u_lane (
      .clk       (clk),
      .stage1_en (in_valid),
      .stage2_en (stage1_valid),
      .op        (in_req.op),
      .din       (in_req.state[i]),
      .dout      (out_state[i])
    );
  end

  // every request leaves exactly SBOX_LATENCY cycles later.
  req_to_result: assert property (
    @(posedge clk) disable iff (reset)
      in_valid |-> ##`SBOX_LATENCY out_valid
  );

  // and no result appears without a request behind it.
  result_from_req: assert property (
    @(posedge clk) disable iff (reset)
      out_valid |-> $past(in_valid, `SBOX_LATENCY)
  );

  legal_op: assert property (
    @(posedge clk) disable iff (reset)
      in_valid |-> (in_req.op inside {SBOX_FWD, SBOX_INV})
  );

endmodule

//--- sim/tb_sbox_layer.sv
`timescale 1ns/100ps
`include "sbox_consts.svh"

module tb_sbox_layer
  import gf_sbox_pkg::*;
();

  typedef enum {QUIET, CHECK_VALUE, ROUND_TRIP, ORDER_SIX, BIJECTION, PIPELINE} test_kind_e;

  typedef struct {
    string       name;
    test_kind_e  kind;
    sbox_op_e    op;
    sbox_state_t stim;
    sbox_state_t want;
  } test_entry_t;

  logic        clk;
  logic        reset;
  logic        in_valid;
  sbox_req_t   in_req;
  logic        out_valid;
  sbox_state_t out_state;

  test_entry_t tests [$];
  sbox_state_t got_q [$];
  logic [31:0] lfsr = 32'd74571;
  logic        sent_d1 = 1'b0; // strobe history, one and two steps back.
  logic        sent_d2 = 1'b0;
  logic        checking = 1'b0;
  int          error_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 1000;

  sbox_layer UUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_state (out_state)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'hA3000000; // galois taps, maximal length.
    end
    return b;
  endfunction

  function automatic sbox_state_t random_state();
    sbox_state_t s;
    for (int i = 0; i < `SBOX_LANES; i++) begin
      for (int j = 0; j < `SBOX_WIDTH; j++) begin
        s[i][j] = next_bit();
      end
    end
    return s;
  endfunction

  function automatic sbox_state_t rotate_lanes(sbox_state_t s);
    sbox_state_t r;
    for (int i = 0; i < `SBOX_LANES; i++) begin
      r[i] = s[(i + 1) % `SBOX_LANES];
    end
    return r;
  endfunction

  function automatic sbox_op_e other_op(sbox_op_e op);
    return (op == SBOX_FWD) ? SBOX_INV : SBOX_FWD;
  endfunction

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_state(string name, sbox_state_t want, sbox_state_t got);
    if (got !== want) begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h", name, want, got);
      stop_on_error();
    end
  endtask

  task automatic check_valid(string name, logic want, logic got);
    if (got !== want) begin
      error_count++;
      $display("FAILED %s: expected %b, actual %b", name, want, got);
      stop_on_error();
    end
  endtask

  // one clock: sample outputs after the edge, then drive the next inputs.
  task automatic step(logic v, sbox_req_t req);
    @(posedge clk);
    #1;
    if (checking) begin
      check_valid("out_valid two cycles after in_valid", sent_d2, out_valid);
      if (out_valid) begin
        got_q.push_back(out_state);
      end
    end
    sent_d2 = sent_d1;
    sent_d1 = v;
    in_valid = v;
    in_req = req;
  endtask

  task automatic send_req(sbox_op_e op, sbox_state_t s);
    sbox_req_t req;
    req.op = op;
    req.state = s;
    step(1'b1, req);
  endtask

  task automatic idle_cycle();
    step(1'b0, '0);
  endtask

  task automatic wait_results(int n);
    while (got_q.size() < n) begin
      idle_cycle();
    end
  endtask

  task automatic apply_one(sbox_op_e op, sbox_state_t s, output sbox_state_t r);
    got_q.delete();
    send_req(op, s);
    wait_results(1);
    r = got_q.pop_front();
  endtask

  task automatic add_test(string name, test_kind_e kind, sbox_op_e op,
                          sbox_state_t stim, sbox_state_t want);
    test_entry_t t;
    t.name = name;
    t.kind = kind;
    t.op = op;
    t.stim = stim;
    t.want = want;
    tests.push_back(t);
  endtask

  task automatic run_round_trip(test_entry_t t);
    sbox_state_t s;
    sbox_state_t mid;
    sbox_state_t back;
    for (int n = 0; n < 4; n++) begin
      s = random_state();
      apply_one(t.op, s, mid);
      apply_one(other_op(t.op), mid, back);
      check_state(t.name, s, back);
    end
  endtask

  task automatic run_order_six(test_entry_t t);
    sbox_state_t s;
    sbox_state_t x;
    s = random_state();
    x = s;
    repeat (6) begin
      apply_one(t.op, x, x);
    end
    check_state(t.name, s, x); // 19^6 and 10^6 are 1 mod 63.
  endtask

  task automatic run_bijection(test_entry_t t);
    sbox_state_t s;
    sbox_state_t r;
    logic [63:0] seen;
    int idx;
    got_q.delete();
    for (int k = 0; k < 11; k++) begin
      for (int i = 0; i < `SBOX_LANES; i++) begin
        s[i] = gf6_t'((k * `SBOX_LANES + i) % 64);
      end
      send_req(t.op, s);
    end
    wait_results(11);
    seen = '0;
    for (int k = 0; k < 11; k++) begin
      r = got_q.pop_front();
      for (int i = 0; i < `SBOX_LANES; i++) begin
        idx = k * `SBOX_LANES + i;
        if (idx < 64) begin
          if (seen[r[i]]) begin
            error_count++;
            $display("%s: output value %h comes from two different inputs", t.name, r[i]);
            stop_on_error();
          end
          seen[r[i]] = 1'b1;
        end
      end
    end
  endtask

  task automatic run_pipeline(test_entry_t t);
    sbox_state_t stim [8];
    sbox_state_t mid [8];
    sbox_op_e    ops [8];
    got_q.delete();
    for (int k = 0; k < 8; k++) begin
      ops[k] = (k / 2 == 1 || k / 2 == 2) ? SBOX_INV : SBOX_FWD;
      stim[k] = (k % 2 == 0) ? random_state() : rotate_lanes(stim[k - 1]); // same lanes moved.
      send_req(ops[k], stim[k]);
    end
    wait_results(8);
    for (int k = 0; k < 8; k++) begin
      mid[k] = got_q.pop_front();
    end
    for (int p = 0; p < 4; p++) begin
      check_state({t.name, " lane independence"}, rotate_lanes(mid[2 * p]), mid[2 * p + 1]);
    end
    for (int k = 0; k < 8; k++) begin
      send_req(other_op(ops[k]), mid[k]);
    end
    wait_results(8);
    for (int k = 0; k < 8; k++) begin
      check_state({t.name, " order and round trip"}, stim[k], got_q.pop_front());
    end
  endtask

  initial begin
    sbox_state_t r;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_req = '0;

    add_test("quiet_after_reset", QUIET, SBOX_FWD, '0, '0);
    add_test("zero_fwd", CHECK_VALUE, SBOX_FWD, '0, '0);
    add_test("zero_inv", CHECK_VALUE, SBOX_INV, '0, '0);
    add_test("one_fwd", CHECK_VALUE, SBOX_FWD, {`SBOX_LANES{6'd1}}, {`SBOX_LANES{6'd1}});
    add_test("one_inv", CHECK_VALUE, SBOX_INV, {`SBOX_LANES{6'd1}}, {`SBOX_LANES{6'd1}});
    add_test("zero_one_mix_inv", CHECK_VALUE, SBOX_INV,
             {6'd1, 6'd0, 6'd0, 6'd1, 6'd1, 6'd0}, {6'd1, 6'd0, 6'd0, 6'd1, 6'd1, 6'd0});
    add_test("round_trip_fwd_inv", ROUND_TRIP, SBOX_FWD, '0, '0);
    add_test("round_trip_inv_fwd", ROUND_TRIP, SBOX_INV, '0, '0);
    add_test("order_six_fwd", ORDER_SIX, SBOX_FWD, '0, '0);
    add_test("order_six_inv", ORDER_SIX, SBOX_INV, '0, '0);
    add_test("bijection_fwd", BIJECTION, SBOX_FWD, '0, '0);
    add_test("pipeline_mixed_ops", PIPELINE, SBOX_FWD, '0, '0);
    cycle_limit = tests.size() * 16 * `SBOX_LATENCY + 64; // longest entry needs about 22.

    repeat (4) idle_cycle();
    reset = 1'b0;
    checking = 1'b1;

    foreach (tests[n]) begin
      case (tests[n].kind)
        QUIET: begin
          repeat (8) begin
            idle_cycle();
            check_valid(tests[n].name, 1'b0, out_valid);
          end
        end
        CHECK_VALUE: begin
          apply_one(tests[n].op, tests[n].stim, r);
          check_state(tests[n].name, tests[n].want, r);
        end
        ROUND_TRIP: run_round_trip(tests[n]);
        ORDER_SIX:  run_order_six(tests[n]);
        BIJECTION:  run_bijection(tests[n]);
        default:    run_pipeline(tests[n]);
      endcase
    end
    repeat (3) idle_cycle(); // no stray strobes after the last result.

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
logic/gf_sbox_pkg.sv
logic/tower_power19.sv
logic/tower_power10.sv
logic/sbox_lane.sv
logic/sbox_layer.sv
sim/tb_sbox_layer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sbox_layer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_sbox_layer \
  -o tb_sbox_layer > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sbox_layer > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -qx "Finished with errors" "$SIM_LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if ! grep -qx "Finished with no errors" "$SIM_LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
